/* hdl/uart_rx_pkg.sv */
`default_nettype none

package uart_rx_pkg;

  // --------------------
  // timing constants, in oversampling ticks
  // --------------------
  localparam int OVERSAMPLE = 16;  // ticks per bit
  localparam int HALF_BIT   = 8;   // start edge to mid-bit
  localparam int IDLE_WAIT  = 6;   // ticks after stop before forcing idle

  // credits held after reset, one per slot of the consumer buffer
  localparam int CREDIT_MAX = 4;

  // --------------------
  // counters and configuration
  // --------------------
  typedef logic [3:0]  tick_cnt_t;
  typedef logic [3:0]  bit_cnt_t;
  typedef logic [2:0]  credit_cnt_t;
  typedef logic [15:0] baud_div_t;   // clocks per tick

  typedef struct packed {
    logic bit8;        // 8 data bits, else 7
    logic parity_en;
    logic odd_n_even;  // odd parity when set
  } rx_cfg_t;

  // one received frame
  typedef struct packed {
    logic [7:0] data;  // bit 7 is zero in 7-bit mode
    logic       parity_err;
    logic       framing_err;
  } rx_word_t;

  typedef struct packed {
    logic overflow;
    logic parity_err;
    logic framing_err;
  } rx_status_t;

endpackage

`default_nettype wire

/* hdl/baud_tick_gen.sv */
`default_nettype none

// one-cycle oversampling tick, once every baud_div clocks
module baud_tick_gen
(
  input  logic                   clk,
  input  logic                   aresetn,
  input  uart_rx_pkg::baud_div_t baud_div,
  output logic                   tick
);
  import uart_rx_pkg::*;

  baud_div_t div_cnt;  // counts down to zero, then reloads

  // --------------------
  // down-counter
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end
    else
    begin
      if (div_cnt == '0)
      begin
        div_cnt <= baud_div - 16'd1;  // period of baud_div clocks
        tick    <= 1'b1;
      end
      else
      begin
        div_cnt <= div_cnt - 16'd1;
        tick    <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/rx_line_filter.sv */
`default_nettype none

// synchronizer and three-sample majority voter on the serial line
module rx_line_filter
(
  input  logic clk,
  input  logic aresetn,
  input  logic tick,
  input  logic rx,
  output logic rx_filt
);

  logic       rx_meta;   // first sync stage
  logic       rx_sync;   // second sync stage
  logic [2:0] samples;   // newest sample in bit 2
  logic       majority;

  // --------------------
  // clock domain crossing
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rx_meta <= 1'b1;  // line idles high
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  // any two of three samples decide the level
  assign majority = (samples[2] & samples[1]) |
                    (samples[2] & samples[0]) |
                    (samples[1] & samples[0]);

  // --------------------
  // sample window and voter output, both stepped on the tick
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      samples <= 3'b111;
      rx_filt <= 1'b1;
    end
    else if (tick)
    begin
      samples <= {rx_sync, samples[2:1]};
      rx_filt <= majority;  // vote of the window before this shift
    end
  end

endmodule

`default_nettype wire

/* hdl/rx_framer.sv */
`default_nettype none

// receive state machine: start qualification, data shift, parity and stop check
module rx_framer
(
  input  logic                  clk,
  input  logic                  aresetn,
  input  logic                  tick,
  input  logic                  rx_filt,
  input  uart_rx_pkg::rx_cfg_t  cfg,
  output logic                  frame_done,
  output uart_rx_pkg::rx_word_t frame
);
  import uart_rx_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_STOP,
    ST_WAIT
  } state_t;

  state_t     state;
  tick_cnt_t  tick_cnt;   // ticks within the current bit
  bit_cnt_t   bit_cnt;    // bits sampled so far in this frame
  bit_cnt_t   last_bit;   // index of the last data or parity bit
  rx_cfg_t    cfg_q;      // format held for the whole frame
  logic [7:0] shift;      // fills from the top
  logic       par_calc;   // xor of data bits
  logic       par_bit;    // received parity bit

  logic       start_ok;   // start bit qualified at mid-bit
  logic       bit_point;  // bit centre in data and stop states
  logic       is_data;    // current sample is a data bit, not parity

  assign start_ok  = tick && (state == ST_IDLE) && !rx_filt &&
                     (tick_cnt == tick_cnt_t'(HALF_BIT - 1));
  assign bit_point = tick && (tick_cnt == tick_cnt_t'(OVERSAMPLE - 1));
  assign is_data   = bit_cnt < (cfg_q.bit8 ? bit_cnt_t'(8) : bit_cnt_t'(7));

  // --------------------
  // state machine and counters
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      last_bit <= '0;
      cfg_q    <= '0;
    end
    else if (tick)
    begin
      case (state)
        ST_IDLE:
        begin
          if (rx_filt)
          begin
            tick_cnt <= '0;  // glitch shorter than half a bit, start over
          end
          else if (start_ok)
          begin
            state    <= ST_DATA;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            cfg_q    <= cfg;
            // 6, 7 or 8 depending on data width and parity
            last_bit <= bit_cnt_t'(6) + bit_cnt_t'(cfg.bit8) +
                        bit_cnt_t'(cfg.parity_en);
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end

        ST_DATA:
        begin
          tick_cnt <= tick_cnt + 1'b1;  // wraps to zero at each bit centre
          if (bit_point)
          begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == last_bit)
            begin
              state <= ST_STOP;
            end
          end
        end

        ST_STOP:
        begin
          tick_cnt <= tick_cnt + 1'b1;
          if (bit_point)
          begin
            state <= ST_WAIT;  // stop sampled, frame_done pulses now
          end
        end

        ST_WAIT:
        begin
          if (rx_filt || (tick_cnt == tick_cnt_t'(IDLE_WAIT - 1)))
          begin
            state    <= ST_IDLE;
            tick_cnt <= '0;
          end
          else
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end

        default:
        begin
          state    <= ST_IDLE;
          tick_cnt <= '0;
        end
      endcase
    end
  end

  // --------------------
  // shift register and running parity
  // --------------------
  always_ff @(posedge clk)
  begin
    if (start_ok)
    begin
      shift    <= '0;
      par_calc <= 1'b0;
      par_bit  <= 1'b0;
    end
    else if (bit_point && (state == ST_DATA))
    begin
      if (is_data)
      begin
        shift    <= {rx_filt, shift[7:1]};
        par_calc <= par_calc ^ rx_filt;
      end
      else
      begin
        par_bit <= rx_filt;  // parity stays out of the data field
      end
    end
  end

  // --------------------
  // frame result, valid on the stop sample
  // --------------------
  assign frame_done = bit_point && (state == ST_STOP);

  // in 7-bit mode the data sits in shift[7:1]
  assign frame.data        = cfg_q.bit8 ? shift : {1'b0, shift[7:1]};
  // even expects par_bit == par_calc, odd expects the inverse
  assign frame.parity_err  = cfg_q.parity_en & (par_bit ^ par_calc ^ cfg_q.odd_n_even);
  assign frame.framing_err = ~rx_filt;  // stop bit must be high

endmodule

`default_nettype wire

/* hdl/rx_delivery.sv */
`default_nettype none

// credit-based word delivery and sticky status flags
module rx_delivery
(
  input  logic                    clk,
  input  logic                    aresetn,
  input  logic                    frame_done,
  input  uart_rx_pkg::rx_word_t   frame,
  input  logic                    credit_return,
  input  logic                    clear_overflow,
  input  logic                    clear_parity,
  input  logic                    clear_framing,
  output logic                    word_valid,
  output uart_rx_pkg::rx_word_t   word,
  output uart_rx_pkg::rx_status_t status
);
  import uart_rx_pkg::*;

  credit_cnt_t credits;     // free slots at the consumer
  logic        has_credit;
  logic        deliver;     // frame goes out
  logic        drop;        // frame lost for lack of credit

  // set wins over clear
  function automatic logic sticky(input logic q, input logic set, input logic clr);
    return set | (q & ~clr);
  endfunction

  assign has_credit = (credits != '0);
  assign deliver    = frame_done & has_credit;
  assign drop       = frame_done & ~has_credit;

  // --------------------
  // credit counter
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      credits <= credit_cnt_t'(CREDIT_MAX);
    end
    else
    begin
      case ({deliver, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;  // none, or spend and return together
      endcase
    end
  end

  // --------------------
  // word output and status
  // --------------------
  always_ff @(posedge clk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      word_valid <= 1'b0;
      status     <= '0;
    end
    else
    begin
      word_valid         <= deliver;
      status.overflow    <= sticky(status.overflow, drop, clear_overflow);
      // errors count whether the frame was delivered or dropped
      status.parity_err  <= sticky(status.parity_err,
                                   frame_done & frame.parity_err, clear_parity);
      status.framing_err <= sticky(status.framing_err,
                                   frame_done & frame.framing_err, clear_framing);
    end
  end

  always_ff @(posedge clk)
  begin
    if (deliver)
    begin
      word <= frame;
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_rx_top.sv */
`default_nettype none

// uart receive path with credit-based delivery
module uart_rx_top
(
  input  logic                    clk,
  input  logic                    aresetn,
  input  logic                    rx,             // serial line, idle high
  input  uart_rx_pkg::rx_cfg_t    cfg,
  input  uart_rx_pkg::baud_div_t  baud_div,       // at least 2
  input  logic                    credit_return,
  input  logic                    clear_overflow,
  input  logic                    clear_parity,
  input  logic                    clear_framing,
  output logic                    word_valid,
  output uart_rx_pkg::rx_word_t   word,
  output uart_rx_pkg::rx_status_t status
);
  import uart_rx_pkg::*;

  logic     tick;        // 16x bit rate
  logic     rx_filt;
  logic     frame_done;
  rx_word_t frame;

  // --------------------
  // oversampling tick
  // --------------------
  baud_tick_gen tick_gen_i
  (
    .clk      (clk),
    .aresetn  (aresetn),
    .baud_div (baud_div),
    .tick     (tick)
  );

  // --------------------
  // line conditioning
  // --------------------
  rx_line_filter filter_i
  (
    .clk     (clk),
    .aresetn (aresetn),
    .tick    (tick),
    .rx      (rx),
    .rx_filt (rx_filt)
  );

  // --------------------
  // frame receive
  // --------------------
  rx_framer framer_i
  (
    .clk        (clk),
    .aresetn    (aresetn),
    .tick       (tick),
    .rx_filt    (rx_filt),
    .cfg        (cfg),
    .frame_done (frame_done),
    .frame      (frame)
  );

  // --------------------
  // delivery to the consumer
  // --------------------
  rx_delivery delivery_i
  (
    .clk            (clk),
    .aresetn        (aresetn),
    .frame_done     (frame_done),
    .frame          (frame),
    .credit_return  (credit_return),
    .clear_overflow (clear_overflow),
    .clear_parity   (clear_parity),
    .clear_framing  (clear_framing),
    .word_valid     (word_valid),
    .word           (word),
    .status         (status)
  );

endmodule

`default_nettype wire

/* test/uart_rx_tb.sv */
`default_nettype none

module uart_rx_tb;
  import uart_rx_pkg::*;

  localparam int BAUD_DIV       = 4;
  localparam int BIT_CLKS       = BAUD_DIV * OVERSAMPLE;
  localparam int FRAME_CLKS     = 12 * BIT_CLKS;  // 11 bits plus one idle bit
  localparam int MAX_FRAMES     = 60;
  localparam int TIMEOUT_CYCLES = MAX_FRAMES * FRAME_CLKS * 2;

  logic       clk = 1'b0;
  logic       aresetn;
  logic       rx;
  rx_cfg_t    cfg;
  baud_div_t  baud_div;
  logic       credit_return;
  logic       clear_overflow;
  logic       clear_parity;
  logic       clear_framing;
  logic       word_valid;
  rx_word_t   word;
  rx_status_t status;

  logic [31:0] lfsr_state = 32'hcac1_56cc;
  rx_word_t    exp_q[$];           // words the model expects, oldest first
  int          delay_q[$];         // credit return delay for each expected word
  rx_status_t  exp_status = '0;
  int          model_credits = CREDIT_MAX;
  int          owed = 0;           // words seen, credit not yet returned
  logic        return_en = 1'b1;
  int          words_seen = 0;
  int          errors = 0;
  int          test_err = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles = 0;

  uart_rx_top dut_i
  (
    .clk            (clk),
    .aresetn        (aresetn),
    .rx             (rx),
    .cfg            (cfg),
    .baud_div       (baud_div),
    .credit_return  (credit_return),
    .clear_overflow (clear_overflow),
    .clear_parity   (clear_parity),
    .clear_framing  (clear_framing),
    .word_valid     (word_valid),
    .word           (word),
    .status         (status)
  );

  always #20 clk = ~clk;

  // --------------------
  // helpers
  // --------------------
  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'hB4BC_D35C) : (lfsr_state >> 1);
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    errors = errors + 1;
  endtask

  task automatic check_status();
    if (status !== exp_status)
    begin
      report_mismatch("status", 32'(exp_status), 32'(status));
    end
  endtask

  task automatic hold_line(input logic level, input int clocks);
    repeat (clocks)
    begin
      @(posedge clk);
      rx <= level;
    end
  endtask

  // one frame on the line; glitch_bit inverts one tick in the middle of that bit
  task automatic send_frame(input rx_cfg_t fmt, input logic [7:0] d, input logic bad_par,
                            input logic bad_stop, input int glitch_bit);
    logic [10:0] levels;
    int          nlev;
    int          i;
    int          half;
    rx_word_t    expected;

    expected.data        = fmt.bit8 ? d : {1'b0, d[6:0]};
    expected.parity_err  = fmt.parity_en & bad_par;
    expected.framing_err = bad_stop;
    levels = '0;  // start bit
    nlev   = 1;
    for (i = 0; i < (fmt.bit8 ? 8 : 7); i++)
    begin
      levels[nlev] = d[i];  // lsb first
      nlev = nlev + 1;
    end
    if (fmt.parity_en)
    begin
      // even makes the count of ones even, odd makes it odd
      levels[nlev] = (^expected.data) ^ fmt.odd_n_even ^ bad_par;
      nlev = nlev + 1;
    end
    levels[nlev] = ~bad_stop;
    nlev = nlev + 1;

    if (model_credits > 0)
    begin
      exp_q.push_back(expected);
      delay_q.push_back(int'(rand_bits(4)));
      model_credits = model_credits - 1;
    end
    else
    begin
      exp_status.overflow = 1'b1;  // dropped for lack of credit
    end
    exp_status.parity_err  = exp_status.parity_err | expected.parity_err;
    exp_status.framing_err = exp_status.framing_err | expected.framing_err;

    half = (BIT_CLKS - BAUD_DIV) / 2;
    @(posedge clk);
    cfg <= fmt;
    for (i = 0; i < nlev; i++)
    begin
      if (i == glitch_bit)
      begin
        hold_line(levels[i], half);
        hold_line(~levels[i], BAUD_DIV);
        hold_line(levels[i], BIT_CLKS - half - BAUD_DIV);
      end
      else
      begin
        hold_line(levels[i], BIT_CLKS);
      end
    end
    hold_line(1'b1, BIT_CLKS);  // idle gap
  endtask

  // pulse the clear inputs picked by mask, then check the flags
  task automatic clear_flags(input rx_status_t mask);
    @(posedge clk);
    clear_overflow <= mask.overflow;
    clear_parity   <= mask.parity_err;
    clear_framing  <= mask.framing_err;
    @(posedge clk);
    clear_overflow <= 1'b0;
    clear_parity   <= 1'b0;
    clear_framing  <= 1'b0;
    exp_status = exp_status & ~mask;
    repeat (2) @(posedge clk);
    check_status();
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
    end
  endtask

  task automatic start_test();
    test_err = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_err)
    begin
      tests_passed = tests_passed + 1;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed = tests_failed + 1;
      $display("test %s: failed with %0d errors", name, errors - test_err);
    end
  endtask

  // --------------------
  // watchdog and word monitor
  // --------------------
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  always @(posedge clk)
  begin : word_monitor
    rx_word_t expected;
    if (aresetn && word_valid)
    begin
      words_seen = words_seen + 1;
      owed       = owed + 1;
      if (exp_q.size() == 0)
      begin
        $display("Error at %0t: word_valid pulsed with no word expected", $time);
        errors = errors + 1;
      end
      else
      begin
        expected = exp_q.pop_front();
        if (word !== expected)
        begin
          report_mismatch("word", 32'(expected), 32'(word));
        end
      end
    end
  end

  // consumer returns one credit per word after a random delay
  initial
  begin : consumer
    int delay;
    credit_return <= 1'b0;
    forever
    begin
      @(posedge clk);
      if (return_en && owed > 0 && delay_q.size() > 0)
      begin
        delay = delay_q.pop_front();
        repeat (delay) @(posedge clk);
        credit_return <= 1'b1;
        owed          = owed - 1;
        model_credits = model_credits + 1;
        @(posedge clk);
        credit_return <= 1'b0;
      end
    end
  end

  // --------------------
  // tests
  // --------------------
  initial
  begin : stimulus
    int c;
    int i;
    int base;
    aresetn        <= 1'b0;
    rx             <= 1'b1;
    cfg            <= rx_cfg_t'(3'b100);
    baud_div       <= baud_div_t'(BAUD_DIV);
    clear_overflow <= 1'b0;
    clear_parity   <= 1'b0;
    clear_framing  <= 1'b0;
    repeat (10) @(posedge clk);
    aresetn <= 1'b1;

    start_test();
    if (word_valid !== 1'b0)
    begin
      report_mismatch("word_valid", 32'd0, 32'(word_valid));
    end
    check_status();
    hold_line(1'b1, 4 * BIT_CLKS);  // idle line, monitor flags any word
    check_status();
    finish_test("1 after reset");

    start_test();
    for (i = 0; i < 12; i++)
    begin
      send_frame(rx_cfg_t'(3'b100), 8'(rand_bits(8)), 1'b0, 1'b0, -1);
    end
    wait_drained();
    check_status();
    finish_test("2 random data");

    start_test();
    for (c = 0; c < 8; c++)
    begin
      send_frame(rx_cfg_t'(c[2:0]), 8'(rand_bits(8)), 1'b0, 1'b0, -1);
      send_frame(rx_cfg_t'(c[2:0]), 8'(rand_bits(8)), 1'b1, 1'b0, -1);
    end
    wait_drained();
    check_status();
    clear_flags(rx_status_t'(3'b010));
    finish_test("3 formats and parity");

    start_test();
    send_frame(rx_cfg_t'(3'b100), 8'(rand_bits(8)), 1'b0, 1'b1, -1);
    send_frame(rx_cfg_t'(3'b010), 8'(rand_bits(8)), 1'b0, 1'b1, -1);
    send_frame(rx_cfg_t'(3'b100), 8'(rand_bits(8)), 1'b0, 1'b0, -1);
    wait_drained();
    check_status();
    clear_flags(rx_status_t'(3'b001));
    finish_test("4 framing");

    start_test();
    while (owed != 0 || delay_q.size() != 0)
    begin
      @(posedge clk);
    end
    return_en = 1'b0;
    base      = words_seen;
    for (i = 0; i < CREDIT_MAX + 2; i++)
    begin
      send_frame(rx_cfg_t'(3'b100), 8'(rand_bits(8)), 1'b0, 1'b0, -1);
    end
    if (words_seen - base != CREDIT_MAX)
    begin
      report_mismatch("words delivered", 32'(CREDIT_MAX), 32'(words_seen - base));
    end
    check_status();
    return_en = 1'b1;
    while (owed != 0)
    begin
      @(posedge clk);
    end
    send_frame(rx_cfg_t'(3'b100), 8'(rand_bits(8)), 1'b0, 1'b0, -1);
    send_frame(rx_cfg_t'(3'b100), 8'(rand_bits(8)), 1'b0, 1'b0, -1);
    wait_drained();
    check_status();
    clear_flags(rx_status_t'(3'b100));
    finish_test("5 credits");

    start_test();
    base = words_seen;
    hold_line(1'b0, BAUD_DIV);  // one-tick low pulse on the idle line
    hold_line(1'b1, 2 * BIT_CLKS);
    if (words_seen != base)
    begin
      report_mismatch("words after glitch", 32'(base), 32'(words_seen));
    end
    for (i = 0; i < 3; i++)
    begin
      send_frame(rx_cfg_t'(3'b100), 8'(rand_bits(8)), 1'b0, 1'b0, 1 + int'(rand_bits(3)));
    end
    wait_drained();
    check_status();
    finish_test("6 glitch filter");

    $display("tests: %0d passed, %0d failed, errors: %0d", tests_passed, tests_failed, errors);
    if (errors == 0)
    begin
      $display("RESULT: PASS");
    end
    else
    begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
hdl/uart_rx_pkg.sv
hdl/baud_tick_gen.sv
hdl/rx_line_filter.sv
hdl/rx_framer.sv
hdl/rx_delivery.sv
hdl/uart_rx_top.sv
test/uart_rx_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module uart_rx_tb
	./obj_dir/Vuart_rx_tb | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
